// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [opcode_w-1:0] {
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    // ADDI x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
    localparam logic [funct3_w-1:0] f3_sll     = 3'b001;
    localparam logic [funct3_w-1:0] f3_slt     = 3'b010;
    localparam logic [funct3_w-1:0] f3_xor     = 3'b100;
    localparam logic [funct3_w-1:0] f3_srl     = 3'b101;
    localparam logic [funct3_w-1:0] f3_or      = 3'b110;
    localparam logic [funct3_w-1:0] f3_and     = 3'b111;
    // LW and SW share this one
    localparam logic [funct3_w-1:0] f3_word    = 3'b010;
    localparam logic [funct3_w-1:0] f3_beq     = 3'b000;
    localparam logic [funct3_w-1:0] f3_bne     = 3'b001;

    localparam logic [funct7_w-1:0] f7_base = 7'b0000000;
    localparam logic [funct7_w-1:0] f7_alt  = 7'b0100000;

endpackage

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        // LUI passes the immediate through
        alu_pass_b = 4'd8
    } alu_op_t;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_eq   = 2'd1,
        br_ne   = 2'd2,
        br_jal  = 2'd3
    } branch_op_t;

    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_t;

endpackage

// ==== fetch_stage.sv ====
module fetch_stage #(
    parameter rv_isa_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              stall,
    input  logic              redirect,
    input  rv_isa_pkg::word_t redirect_pc,
    input  rv_isa_pkg::word_t instr,
    output rv_isa_pkg::word_t instr_addr,
    output rv_isa_pkg::word_t if_pc,
    output rv_isa_pkg::word_t if_instr
);
    import rv_isa_pkg::*;

    word_t pc;

    assign instr_addr = pc;

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID, squashed to a NOP behind a taken branch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_instr <= nop_instr;
        end else if (redirect) begin
            if_instr <= nop_instr;
        end else if (!stall) begin
            if_instr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect || !stall) begin
            if_pc <= pc;
        end
    end

endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_isa_pkg::word_t       if_pc,
    input  rv_isa_pkg::word_t       if_instr,
    input  logic                    redirect,
    input  rv_isa_pkg::word_t       rs1_val,
    input  rv_isa_pkg::word_t       rs2_val,
    output rv_isa_pkg::reg_addr_t   rs1,
    output rv_isa_pkg::reg_addr_t   rs2,
    output logic                    stall,
    output rv_isa_pkg::word_t       ex_pc,
    output rv_isa_pkg::word_t       ex_rs1_val,
    output rv_isa_pkg::word_t       ex_rs2_val,
    output rv_isa_pkg::reg_addr_t   ex_rs1,
    output rv_isa_pkg::reg_addr_t   ex_rs2,
    output rv_isa_pkg::reg_addr_t   ex_rd,
    output logic                    ex_rd_we,
    output rv_isa_pkg::word_t       ex_imm,
    output rv_pipe_pkg::alu_op_t    ex_alu_op,
    output logic                    ex_use_imm,
    output rv_pipe_pkg::mem_op_t    ex_mem_op,
    output rv_pipe_pkg::branch_op_t ex_branch_op
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    opcode_t             opcode;
    logic [funct3_w-1:0] funct3;
    logic [funct7_w-1:0] funct7;
    reg_addr_t           rd;
    word_t               imm;
    alu_op_t             alu_op;
    logic                use_imm;
    mem_op_t             mem_op;
    branch_op_t          branch_op;
    logic                use_rs1;
    logic                use_rs2;
    logic                rd_we;

    assign opcode = opcode_t'(if_instr[opcode_w-1:0]);
    assign funct3 = if_instr[14:12];
    assign funct7 = if_instr[31:25];
    assign rd     = if_instr[11:7];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    // Anything outside the subset leaves every default in place, i.e. a NOP
    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b0;
        mem_op    = mem_none;
        branch_op = br_none;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        rd_we     = 1'b0;
        imm       = '0;
        case (opcode)
            op_lui: begin
                alu_op  = alu_pass_b;
                use_imm = 1'b1;
                rd_we   = 1'b1;
                imm     = {if_instr[31:12], 12'b0};
            end
            op_imm: begin
                // ADDI only
                if (funct3 == f3_add_sub) begin
                    use_imm = 1'b1;
                    use_rs1 = 1'b1;
                    rd_we   = 1'b1;
                    imm     = {{20{if_instr[31]}}, if_instr[31:20]};
                end
            end
            op_reg: begin
                rd_we = 1'b1;
                case ({funct7, funct3})
                    {f7_base, f3_add_sub}: alu_op = alu_add;
                    {f7_alt, f3_add_sub}:  alu_op = alu_sub;
                    {f7_base, f3_and}:     alu_op = alu_and;
                    {f7_base, f3_or}:      alu_op = alu_or;
                    {f7_base, f3_xor}:     alu_op = alu_xor;
                    {f7_base, f3_slt}:     alu_op = alu_slt;
                    {f7_base, f3_sll}:     alu_op = alu_sll;
                    {f7_base, f3_srl}:     alu_op = alu_srl;
                    default:               rd_we  = 1'b0;
                endcase
                use_rs1 = rd_we;
                use_rs2 = rd_we;
            end
            op_load: begin
                if (funct3 == f3_word) begin
                    mem_op  = mem_load;
                    use_imm = 1'b1;
                    use_rs1 = 1'b1;
                    rd_we   = 1'b1;
                    imm     = {{20{if_instr[31]}}, if_instr[31:20]};
                end
            end
            op_store: begin
                if (funct3 == f3_word) begin
                    mem_op  = mem_store;
                    use_imm = 1'b1;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    imm     = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
                end
            end
            op_branch: begin
                if (funct3 == f3_beq || funct3 == f3_bne) begin
                    branch_op = (funct3 == f3_beq) ? br_eq : br_ne;
                    use_rs1   = 1'b1;
                    use_rs2   = 1'b1;
                    imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                           if_instr[30:25], if_instr[11:8], 1'b0};
                end
            end
            op_jal: begin
                branch_op = br_jal;
                rd_we     = 1'b1;
                imm = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                       if_instr[20], if_instr[30:21], 1'b0};
            end
            default: begin
            end
        endcase
    end

    // Load in ID/EX feeding a source read here; ex_rd_we already excludes x0
    assign stall = (ex_mem_op == mem_load) && ex_rd_we &&
                   ((use_rs1 && rs1 == ex_rd) || (use_rs2 && rs2 == ex_rd));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_rd_we     <= 1'b0;
            ex_mem_op    <= mem_none;
            ex_branch_op <= br_none;
        end else if (stall || redirect) begin
            ex_rd_we     <= 1'b0;
            ex_mem_op    <= mem_none;
            ex_branch_op <= br_none;
        end else begin
            ex_rd_we     <= rd_we && (rd != '0);
            ex_mem_op    <= mem_op;
            ex_branch_op <= branch_op;
        end
    end

    // Unused sources go down as x0 so they never match a forward
    always_ff @(posedge clk) begin
        ex_pc      <= if_pc;
        ex_rs1_val <= rs1_val;
        ex_rs2_val <= rs2_val;
        ex_rs1     <= use_rs1 ? rs1 : '0;
        ex_rs2     <= use_rs2 ? rs2 : '0;
        ex_rd      <= rd;
        ex_imm     <= imm;
        ex_alu_op  <= alu_op;
        ex_use_imm <= use_imm;
    end

endmodule

// ==== register_file.sv ====
module register_file #(
    parameter int num_regs = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_isa_pkg::reg_addr_t rs1,
    input  rv_isa_pkg::reg_addr_t rs2,
    output rv_isa_pkg::word_t     rs1_val,
    output rv_isa_pkg::word_t     rs2_val,
    input  rv_isa_pkg::reg_addr_t wb_rd,
    input  logic                  wb_we,
    input  rv_isa_pkg::word_t     wb_value
);
    import rv_isa_pkg::*;

    word_t regs [num_regs];

    // x0 and indices past the file read zero, a same-cycle write reads through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0 || int'(addr) >= num_regs) begin
            return '0;
        end
        if (wb_we && addr == wb_rd) begin
            return wb_value;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0 && int'(wb_rd) < num_regs) begin
            regs[wb_rd] <= wb_value;
        end
    end

endmodule

// ==== execute_stage.sv ====
module execute_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rv_isa_pkg::word_t       ex_pc,
    input  rv_isa_pkg::word_t       ex_rs1_val,
    input  rv_isa_pkg::word_t       ex_rs2_val,
    input  rv_isa_pkg::reg_addr_t   ex_rs1,
    input  rv_isa_pkg::reg_addr_t   ex_rs2,
    input  rv_isa_pkg::reg_addr_t   ex_rd,
    input  logic                    ex_rd_we,
    input  rv_isa_pkg::word_t       ex_imm,
    input  rv_pipe_pkg::alu_op_t    ex_alu_op,
    input  logic                    ex_use_imm,
    input  rv_pipe_pkg::mem_op_t    ex_mem_op,
    input  rv_pipe_pkg::branch_op_t ex_branch_op,
    input  rv_isa_pkg::reg_addr_t   wb_rd,
    input  logic                    wb_we,
    input  rv_isa_pkg::word_t       wb_value,
    output logic                    redirect,
    output rv_isa_pkg::word_t       redirect_pc,
    output rv_isa_pkg::reg_addr_t   mem_rd,
    output logic                    mem_rd_we,
    output rv_isa_pkg::word_t       mem_result,
    output rv_isa_pkg::word_t       mem_store_data,
    output rv_pipe_pkg::mem_op_t    mem_op
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    word_t    op_a;
    word_t    rs2_fwd;
    word_t    op_b;
    word_t    alu_out;
    word_t    result;

    // EX/MEM is younger than writeback, so it is checked first.
    // A load never sits in EX/MEM with a consumer here, the stall sees to that
    function automatic fwd_sel_t pick_source(reg_addr_t rs);
        if (rs == '0) begin
            return fwd_reg;
        end
        if (mem_rd_we && mem_rd == rs) begin
            return fwd_mem;
        end
        if (wb_we && wb_rd == rs) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    function automatic word_t forward(fwd_sel_t sel, word_t reg_val);
        case (sel)
            fwd_mem: return mem_result;
            fwd_wb:  return wb_value;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_a   = pick_source(ex_rs1);
        fwd_b   = pick_source(ex_rs2);
        op_a    = forward(fwd_a, ex_rs1_val);
        rs2_fwd = forward(fwd_b, ex_rs2_val);
    end

    assign op_b = ex_use_imm ? ex_imm : rs2_fwd;

    always_comb begin
        case (ex_alu_op)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll:    alu_out = op_a << op_b[$clog2(xlen)-1:0];
            alu_srl:    alu_out = op_a >> op_b[$clog2(xlen)-1:0];
            alu_pass_b: alu_out = op_b;
            // Also the load and store address
            default:    alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ex_branch_op)
            br_eq:   redirect = (op_a == rs2_fwd);
            br_ne:   redirect = (op_a != rs2_fwd);
            br_jal:  redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    assign redirect_pc = ex_pc + ex_imm;

    // JAL links to the next instruction
    assign result = (ex_branch_op == br_jal) ? ex_pc + 32'd4 : alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rd_we <= 1'b0;
            mem_op    <= mem_none;
        end else begin
            mem_rd_we <= ex_rd_we;
            mem_op    <= ex_mem_op;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd         <= ex_rd;
        mem_result     <= result;
        mem_store_data <= rs2_fwd;
    end

endmodule

// ==== result_stage.sv ====
module result_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_isa_pkg::reg_addr_t mem_rd,
    input  logic                  mem_rd_we,
    input  rv_isa_pkg::word_t     mem_result,
    input  rv_isa_pkg::word_t     mem_store_data,
    input  rv_pipe_pkg::mem_op_t  mem_op,
    input  rv_isa_pkg::word_t     data_rdata,
    output rv_isa_pkg::word_t     data_addr,
    output rv_isa_pkg::word_t     data_wdata,
    output logic                  data_re,
    output logic                  data_we,
    output rv_isa_pkg::reg_addr_t wb_rd,
    output logic                  wb_we,
    output rv_isa_pkg::word_t     wb_value
);
    import rv_pipe_pkg::*;

    // Memory answers within the cycle, so the strobes need no handshake
    assign data_re    = (mem_op == mem_load);
    assign data_we    = (mem_op == mem_store);
    assign data_addr  = mem_result;
    assign data_wdata = mem_store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_rd_we;
        end
    end

    // Writeback value is picked here so it leaves straight from a flop
    always_ff @(posedge clk) begin
        wb_rd    <= mem_rd;
        wb_value <= data_re ? data_rdata : mem_result;
    end

endmodule

// ==== riscv_core.sv ====
module riscv_core #(
    parameter rv_isa_pkg::word_t reset_pc = '0,
    parameter int                num_regs = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    output rv_isa_pkg::word_t instr_addr,
    input  rv_isa_pkg::word_t instr,
    output rv_isa_pkg::word_t data_addr,
    output rv_isa_pkg::word_t data_wdata,
    input  rv_isa_pkg::word_t data_rdata,
    output logic              data_re,
    output logic              data_we
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // IF/ID and hazard control
    word_t      if_pc;
    word_t      if_instr;
    logic       stall;
    logic       redirect;
    word_t      redirect_pc;

    // Register file read side
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_val;
    word_t      rs2_val;

    // ID/EX
    word_t      ex_pc;
    word_t      ex_rs1_val;
    word_t      ex_rs2_val;
    reg_addr_t  ex_rs1;
    reg_addr_t  ex_rs2;
    reg_addr_t  ex_rd;
    logic       ex_rd_we;
    word_t      ex_imm;
    alu_op_t    ex_alu_op;
    logic       ex_use_imm;
    mem_op_t    ex_mem_op;
    branch_op_t ex_branch_op;

    // EX/MEM
    reg_addr_t  mem_rd;
    logic       mem_rd_we;
    word_t      mem_result;
    word_t      mem_store_data;
    mem_op_t    mem_op;

    // MEM/WB
    reg_addr_t  wb_rd;
    logic       wb_we;
    word_t      wb_value;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) u_fetch_stage (.*);

    decode_stage u_decode_stage (.*);

    register_file #(
        .num_regs(num_regs)
    ) u_register_file (.*);

    execute_stage u_execute_stage (.*);

    result_stage u_result_stage (.*);

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

// ==== riscv_core_props.sv ====
module riscv_core_props (
    input logic              clk,
    input logic              arst_n,
    input rv_isa_pkg::word_t instr_addr,
    input logic              data_re,
    input logic              data_we
);

    // At most one data access per cycle
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(data_re && data_we)
    ) else $error("data_re and data_we are high in the same cycle");

    // Quiet bus while in reset and on the first edge after release
    strobes_idle_in_reset: assert property (
        @(posedge clk) (!arst_n || $rose(arst_n)) |-> (!data_re && !data_we)
    ) else $error("a data strobe is high during or right after reset");

    fetch_aligned: assert property (
        @(posedge clk) instr_addr[1:0] == 2'b00
    ) else $error("instr_addr %h is not word aligned", instr_addr);

endmodule

// ==== tb_riscv_core.sv ====
module tb_riscv_core;
    import rv_isa_pkg::*;

    localparam word_t reset_pc      = 32'h0000_0100;
    localparam int    mem_words     = 256;
    localparam int    store_timeout = 200;
    localparam int    quiet_cycles  = 50;

    logic  clk;
    logic  arst_n;
    word_t instr_addr;
    word_t instr;
    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    logic  data_re;
    logic  data_we;

    word_t prog [mem_words];
    word_t dmem [mem_words];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    stores_seen;
    int    value_errors;
    int    other_errors;

    tb_clock #(
        .period(4)
    ) u_tb_clock (
        .clk(clk)
    );

    riscv_core #(
        .reset_pc(reset_pc),
        .num_regs(32)
    ) u_riscv_core (.*);

    bind riscv_core riscv_core_props u_riscv_core_props (
        .clk(clk),
        .arst_n(arst_n),
        .instr_addr(instr_addr),
        .data_re(data_re),
        .data_we(data_we)
    );

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        assert (actual == expected) else begin
            value_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        string line;
        byte   kind;
        word_t addr;
        word_t value;
        // Unwritten program words have a zero opcode and run as NOPs
        for (int i = 0; i < mem_words; i++) begin
            prog[i] = word_t'(i) << 9;
            dmem[i] = 32'h5a00_0000 | (word_t'(i) << 2);
        end
        fd = $fopen("riscv_core_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open riscv_core_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%c %h %h", kind, addr, value) == 3) begin
                case (kind)
                    "p": prog[addr[9:2]] = value;
                    "d": dmem[addr[9:2]] = value;
                    "s": begin
                        exp_addr.push_back(addr);
                        exp_data.push_back(value);
                    end
                    default: begin
                    end
                endcase
            end
        end
        $fclose(fd);
        if (exp_addr.size() == 0) begin
            other_errors++;
            $display("The vector file holds no expected stores");
        end
    endtask

    task automatic record_store();
        assert (stores_seen < exp_addr.size()) else begin
            other_errors++;
            $display("Unexpected extra store to %h at time %0t", data_addr, $time);
        end
        if (stores_seen < exp_addr.size()) begin
            check_value("data_addr", data_addr, exp_addr[stores_seen]);
            check_value("data_wdata", data_wdata, exp_data[stores_seen]);
        end
        dmem[data_addr[9:2]] = data_wdata;
        stores_seen++;
    endtask

    // Memory models answer on the falling edge
    initial begin
        instr      = nop_instr;
        data_rdata = '0;
        forever begin
            @(negedge clk);
            if (data_we) begin
                record_store();
            end
            instr      = prog[instr_addr[9:2]];
            data_rdata = data_re ? dmem[data_addr[9:2]] : '0;
        end
    end

    task automatic check_reset();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_value("instr_addr", instr_addr, reset_pc);
            check_value("data_re", word_t'(data_re), '0);
            check_value("data_we", word_t'(data_we), '0);
        end
        arst_n = 1'b1;
        #1;
        check_value("instr_addr", instr_addr, reset_pc);
        check_value("data_re", word_t'(data_re), '0);
        check_value("data_we", word_t'(data_we), '0);
        @(negedge clk);
        check_value("data_re", word_t'(data_re), '0);
        check_value("data_we", word_t'(data_we), '0);
    endtask

    task automatic wait_for_stores();
        int cycles;
        cycles = 0;
        while (stores_seen < exp_addr.size() && cycles < store_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (stores_seen < exp_addr.size()) begin
            other_errors++;
            $display("Timed out after %0d cycles, only %0d of %0d stores seen",
                     cycles, stores_seen, exp_addr.size());
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        stores_seen  = 0;
        value_errors = 0;
        other_errors = 0;
        load_vectors();
        check_reset();
        wait_for_stores();
        // Final loop must stay silent on the data bus
        for (int i = 0; i < quiet_cycles; i++) begin
            @(posedge clk);
        end
        $display("Check summary: %0d wrong values, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== riscv_core_vectors.txt ====
# Columns are kind, hex address and hex value, anything after them is ignored
# Kind p is a program word, d an initial data word, s an expected store in order
p 00000100 123450b7 lui  x1, 0x12345
p 00000104 67808113 addi x2, x1, 0x678
p 00000108 001101b3 add  x3, x2, x1
p 0000010c 08302023 sw   x3, 0x80(x0)
p 00000110 40218233 sub  x4, x3, x2
p 00000114 002242b3 xor  x5, x4, x2
p 00000118 00800413 addi x8, x0, 8
p 0000011c 00829333 sll  x6, x5, x8
p 00000120 003363b3 or   x7, x6, x3
p 00000124 0023f4b3 and  x9, x7, x2
p 00000128 0084d533 srl  x10, x9, x8
p 0000012c 40a005b3 sub  x11, x0, x10
p 00000130 00a5a633 slt  x12, x11, x10
p 00000134 08c02223 sw   x12, 0x84(x0)
p 00000138 08a02423 sw   x10, 0x88(x0)
p 0000013c 08702623 sw   x7, 0x8c(x0)
p 00000140 04002683 lw   x13, 0x40(x0)
p 00000144 00368733 add  x14, x13, x3
p 00000148 08e02823 sw   x14, 0x90(x0)
p 0000014c dead0fb7 lui  x31, 0xdead0
p 00000150 00b60663 beq  x12, x11, +12 not taken
p 00000154 00c61663 bne  x12, x12, +12 not taken
p 00000158 08c02a23 sw   x12, 0x94(x0)
p 0000015c 00a50663 beq  x10, x10, +12 taken
p 00000160 0bf02023 sw   x31, 0xa0(x0) shadow
p 00000164 0bf02023 sw   x31, 0xa0(x0) shadow
p 00000168 00c51663 bne  x10, x12, +12 taken
p 0000016c 0bf02023 sw   x31, 0xa0(x0) shadow
p 00000170 0bf02023 sw   x31, 0xa0(x0) shadow
p 00000174 00c007ef jal  x15, +12
p 00000178 0bf02023 sw   x31, 0xa0(x0) shadow
p 0000017c 0bf02023 sw   x31, 0xa0(x0) shadow
p 00000180 08f02c23 sw   x15, 0x98(x0)
p 00000184 0000006f jal  x0, 0
d 00000040 01020304
s 00000080 2468a678
s 00000084 00000001
s 00000088 00002456
s 0000008c 246efe78
s 00000090 256aa97c
s 00000094 00000001
s 00000098 00000178

// ==== filelist.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
result_stage.sv
riscv_core.sv
tb_clock.sv
riscv_core_props.sv
tb_riscv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_riscv_core -f filelist.f -o sim_riscv_core \
    && ./obj_dir/sim_riscv_core 2>&1 | tee sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
